//--- design/board_pkg.sv
// Board glue widths, GPIO and interrupt types, controller states and timing constants
`default_nettype none

package board_pkg;

    // GPIO widths
    localparam int BTN_WIDTH = 5;
    localparam int SW_WIDTH = 8;
    localparam int GPIO_WIDTH = BTN_WIDTH + SW_WIDTH;

    // Interrupt lines and pulse stretch length
    localparam int IRQ_COUNT = 32;
    localparam int IRQ_STRETCH = 10;

    // Debounce, board rate is 250000
    localparam int DEBOUNCE_SAMPLES = 4;
    localparam int DEBOUNCE_RATE = 16;

    // Reset sequencing
    localparam int LOCK_SYNC_STAGES = 2;
    localparam int RESET_HOLD_CYCLES = 4;

    localparam int RATE_CNT_WIDTH = $clog2(DEBOUNCE_RATE);
    localparam int HOLD_CNT_WIDTH = $clog2(RESET_HOLD_CYCLES);

    // Buttons from MSB: up, left, down, right, center
    typedef logic [BTN_WIDTH-1:0] btn_t;
    typedef logic [SW_WIDTH-1:0] sw_t;

    typedef struct packed {
        btn_t btn;
        sw_t  sw;
    } gpio_t;

    typedef logic [IRQ_COUNT-1:0] irq_vec_t;

    typedef logic [RATE_CNT_WIDTH-1:0] rate_cnt_t;
    typedef logic [HOLD_CNT_WIDTH-1:0] hold_cnt_t;

    // Terminal counts
    localparam rate_cnt_t RATE_CNT_LAST = rate_cnt_t'(DEBOUNCE_RATE - 1);
    localparam hold_cnt_t HOLD_CNT_LAST = hold_cnt_t'(RESET_HOLD_CYCLES - 1);

    typedef enum logic [1:0] {
        WAIT_LOCK,
        HOLD,
        RUN
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/board_ctrl.sv
// Lock synchronizer, reset sequencing FSM, DDR reset and debounce strobe divider
`timescale 1ns/100ps
`default_nettype none

module board_ctrl (
    input  logic zynq_pl_clk,
    input  logic zynq_pl_reset,
    input  logic clk_locked,
    output logic core_reset,
    output logic ddr_reset,
    output logic sample_strobe
);

    logic [board_pkg::LOCK_SYNC_STAGES-1:0] lock_sync;
    logic lock_synced;

    board_pkg::ctrl_state_t state;
    board_pkg::ctrl_state_t state_next;
    board_pkg::hold_cnt_t hold_cnt;
    board_pkg::rate_cnt_t rate_cnt;

    // Lock comes straight from the clock manager
    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            lock_sync <= '0;
        end else begin
            lock_sync <= {lock_sync[board_pkg::LOCK_SYNC_STAGES-2:0], clk_locked};
        end
    end

    assign lock_synced = lock_sync[board_pkg::LOCK_SYNC_STAGES-1];

    always_comb begin
        state_next = state;
        case (state)
            board_pkg::WAIT_LOCK: begin
                if (lock_synced) begin
                    state_next = board_pkg::HOLD;
                end
            end
            board_pkg::HOLD: begin
                if (!lock_synced) begin
                    state_next = board_pkg::WAIT_LOCK;
                end else if (hold_cnt == board_pkg::HOLD_CNT_LAST) begin
                    state_next = board_pkg::RUN;
                end
            end
            board_pkg::RUN: begin
                if (!lock_synced) begin
                    state_next = board_pkg::WAIT_LOCK;
                end
            end
            default: begin
                state_next = board_pkg::WAIT_LOCK;
            end
        endcase
    end

    // core_reset follows the next state so it lines up with state
    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            state <= board_pkg::WAIT_LOCK;
            hold_cnt <= '0;
            core_reset <= 1'b1;
        end else begin
            state <= state_next;
            core_reset <= (state_next != board_pkg::RUN);
            if (state == board_pkg::HOLD) begin
                hold_cnt <= hold_cnt + 1'b1;
            end else begin
                hold_cnt <= '0;
            end
        end
    end

    // DDR comes out of reset one cycle after the PS reset
    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            ddr_reset <= 1'b1;
        end else begin
            ddr_reset <= 1'b0;
        end
    end

    // Strobe divider runs only once the core is out of reset
    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            rate_cnt <= '0;
            sample_strobe <= 1'b0;
        end else if (state != board_pkg::RUN) begin
            rate_cnt <= '0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= (rate_cnt == board_pkg::RATE_CNT_LAST);
            if (rate_cnt == board_pkg::RATE_CNT_LAST) begin
                rate_cnt <= '0;
            end else begin
                rate_cnt <= rate_cnt + 1'b1;
            end
        end
    end

    // Release only after lock was seen through the whole hold
    core_reset_release_after_hold: assert property (
        @(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        $fell(core_reset) |-> $past(lock_synced, board_pkg::RESET_HOLD_CYCLES + 1)
    );

    strobe_single_cycle: assert property (
        @(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        sample_strobe |=> !sample_strobe
    );

endmodule

`default_nettype wire

//--- design/gpio_debounce.sv
// Button and switch debouncer with per-bit sample history
`timescale 1ns/100ps
`default_nettype none

module gpio_debounce (
    input  logic             zynq_pl_clk,
    input  logic             zynq_pl_reset,
    input  logic             sample_strobe,
    input  board_pkg::gpio_t gpio_raw,
    output board_pkg::gpio_t gpio_clean
);

    logic [board_pkg::GPIO_WIDTH-1:0] raw_bits;
    logic [board_pkg::GPIO_WIDTH-1:0] clean_bits;

    // One sample history per GPIO bit, newest sample in bit 0
    logic [board_pkg::GPIO_WIDTH-1:0][board_pkg::DEBOUNCE_SAMPLES-1:0] history;
    logic [board_pkg::GPIO_WIDTH-1:0][board_pkg::DEBOUNCE_SAMPLES-1:0] history_next;

    assign raw_bits = gpio_raw;

    always_comb begin
        for (int i = 0; i < board_pkg::GPIO_WIDTH; i++) begin
            history_next[i] = {history[i][board_pkg::DEBOUNCE_SAMPLES-2:0], raw_bits[i]};
        end
    end

    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            history <= '0;
        end else if (sample_strobe) begin
            history <= history_next;
        end
    end

    // Output moves only when every sample agrees
    always_ff @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            clean_bits <= '0;
        end else if (sample_strobe) begin
            for (int i = 0; i < board_pkg::GPIO_WIDTH; i++) begin
                if (&history_next[i]) begin
                    clean_bits[i] <= 1'b1;
                end else if (~|history_next[i]) begin
                    clean_bits[i] <= 1'b0;
                end
            end
        end
    end

    assign gpio_clean = clean_bits;

    clean_moves_after_strobe: assert property (
        @(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        $changed(gpio_clean) |-> $past(sample_strobe)
    );

endmodule

`default_nettype wire

//--- design/irq_stretch.sv
// Interrupt pulse stretcher built from a shift vector and per-line OR
`timescale 1ns/100ps
`default_nettype none

module irq_stretch (
    input  logic                zynq_pl_clk,
    input  logic                core_reset,
    input  board_pkg::irq_vec_t irq,
    output board_pkg::irq_vec_t zynq_irq
);

    // Stage 0 holds the newest interrupt vector
    board_pkg::irq_vec_t [board_pkg::IRQ_STRETCH-1:0] stages;

    always_ff @(posedge zynq_pl_clk or posedge core_reset) begin
        if (core_reset) begin
            stages <= '0;
        end else begin
            stages <= {stages[board_pkg::IRQ_STRETCH-2:0], irq};
        end
    end

    // A line is high while its pulse is in any stage
    always_comb begin
        zynq_irq = '0;
        for (int i = 0; i < board_pkg::IRQ_STRETCH; i++) begin
            zynq_irq = zynq_irq | stages[i];
        end
    end

    for (genvar k = 0; k < board_pkg::IRQ_COUNT; k++) begin : g_line_check
        irq_line_has_source: assert property (
            @(posedge zynq_pl_clk) disable iff (core_reset)
            !irq[k] [*board_pkg::IRQ_STRETCH] |=> !zynq_irq[k]
        );
    end

endmodule

`default_nettype wire

//--- design/zynq_board_glue.sv
// Board glue top level with reset control, GPIO debounce and interrupt stretch
`timescale 1ns/100ps
`default_nettype none

module zynq_board_glue (
    input  logic                zynq_pl_clk,
    input  logic                zynq_pl_reset,
    input  logic                clk_locked,
    input  board_pkg::gpio_t    gpio_raw,
    input  board_pkg::irq_vec_t irq,
    output board_pkg::gpio_t    gpio_clean,
    output board_pkg::irq_vec_t zynq_irq,
    output logic                core_reset,
    output logic                ddr_reset
);

    logic sample_strobe;

    board_ctrl board_ctrl_inst (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .clk_locked    (clk_locked),
        .core_reset    (core_reset),
        .ddr_reset     (ddr_reset),
        .sample_strobe (sample_strobe)
    );

    // Freezes while the core is held in reset since the strobe stops
    gpio_debounce gpio_debounce_inst (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .sample_strobe (sample_strobe),
        .gpio_raw      (gpio_raw),
        .gpio_clean    (gpio_clean)
    );

    irq_stretch irq_stretch_inst (
        .zynq_pl_clk (zynq_pl_clk),
        .core_reset  (core_reset),
        .irq         (irq),
        .zynq_irq    (zynq_irq)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic zynq_pl_clk,
    output logic zynq_pl_reset
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        zynq_pl_clk = 1'b0;
        forever #(HALF_PERIOD) zynq_pl_clk = ~zynq_pl_clk;
    end

    // Released just after an edge, like the other inputs
    initial begin
        zynq_pl_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge zynq_pl_clk);
        #2;
        zynq_pl_reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/board_glue_checker.sv
// Output watcher with trace expectations, reset timing rules and error counts
`timescale 1ns/100ps
`default_nettype none

module board_glue_checker (
    input  logic                zynq_pl_clk,
    input  logic                zynq_pl_reset,
    input  logic                clk_locked,
    input  logic                core_reset,
    input  logic                ddr_reset,
    input  board_pkg::gpio_t    gpio_clean,
    input  board_pkg::irq_vec_t zynq_irq
);

    // Release window counted in cycles after clk_locked changes
    localparam int RELEASE_MIN = board_pkg::LOCK_SYNC_STAGES + board_pkg::RESET_HOLD_CYCLES;
    localparam int RELEASE_MAX = RELEASE_MIN + 2;
    localparam int LOSS_MAX = 3;

    int error_count = 0;
    int check_count = 0;

    string       pend_name[$];
    int          pend_sel[$];
    logic [31:0] pend_value[$];

    int   edges_since_reset = 0;
    int   since_lock = 0;
    int   since_drop = LOSS_MAX;
    logic lock_seen = 1'b0;
    logic window_open = 1'b0;
    logic released = 1'b0;

    task automatic post_expect(input string name, input int sel, input logic [31:0] value);
        pend_name.push_back(name);
        pend_sel.push_back(sel);
        pend_value.push_back(value);
    endtask

    task automatic flag_problem(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    // Selector codes: 0 core_reset, 1 ddr_reset, 2 gpio_clean, 3 zynq_irq
    function automatic logic [31:0] output_value(input int sel);
        case (sel)
            0: return {31'b0, core_reset};
            1: return {31'b0, ddr_reset};
            2: return {19'b0, gpio_clean};
            default: return zynq_irq;
        endcase
    endfunction

    task automatic compare_pending();
        string       name;
        int          sel;
        logic [31:0] expected;
        logic [31:0] actual;
        while (pend_sel.size() > 0) begin
            name = pend_name.pop_front();
            sel = pend_sel.pop_front();
            expected = pend_value.pop_front();
            actual = output_value(sel);
            check_count++;
            if (actual !== expected) begin
                $display("FAILED %s expected %h actual %h", name, expected, actual);
                error_count++;
            end
        end
    endtask

    task automatic check_ddr_reset();
        if (zynq_pl_reset) begin
            if (!ddr_reset) begin
                flag_problem("ddr_reset is low while zynq_pl_reset is high");
            end
        end else if (edges_since_reset == 0) begin
            if (!ddr_reset) begin
                flag_problem("ddr_reset fell before the first edge after reset");
            end
        end else if (ddr_reset) begin
            flag_problem("ddr_reset is still high after the first edge after reset");
        end
    endtask

    task automatic track_core_reset();
        if (zynq_pl_reset) begin
            lock_seen = 1'b0;
            window_open = 1'b0;
            released = 1'b0;
            since_drop = LOSS_MAX;
        end else if (clk_locked) begin
            since_drop = 0;
            if (!lock_seen) begin
                lock_seen = 1'b1;
                since_lock = 0;
                window_open = 1'b1;
                released = 1'b0;
            end else begin
                since_lock++;
            end
            if (window_open) begin
                if (!core_reset) begin
                    if (since_lock < RELEASE_MIN) begin
                        flag_problem("core_reset fell too early after clk_locked rose");
                    end
                    window_open = 1'b0;
                    released = 1'b1;
                end else if (since_lock > RELEASE_MAX) begin
                    flag_problem("core_reset did not fall in time after clk_locked rose");
                    window_open = 1'b0;
                end
            end else if (released && core_reset) begin
                flag_problem("core_reset rose while clk_locked stayed high");
            end
        end else begin
            lock_seen = 1'b0;
            window_open = 1'b0;
            released = 1'b0;
            if (since_drop >= LOSS_MAX && !core_reset) begin
                flag_problem("core_reset is low although clk_locked has been low for 3 cycles");
            end
            if (since_drop < LOSS_MAX) begin
                since_drop++;
            end
        end
    endtask

    always @(posedge zynq_pl_clk or posedge zynq_pl_reset) begin
        if (zynq_pl_reset) begin
            edges_since_reset <= 0;
        end else if (edges_since_reset < 2) begin
            edges_since_reset <= edges_since_reset + 1;
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge zynq_pl_clk) begin
        check_ddr_reset();
        track_core_reset();
        if (core_reset && zynq_irq != '0) begin
            flag_problem("zynq_irq is active while core_reset is high");
        end
        compare_pending();
    end

endmodule

`default_nettype wire

//--- verification/board_glue_tb.sv
// Testbench top with trace replay, DUT instance and run timeout
`timescale 1ns/100ps
`default_nettype none

module board_glue_tb;

    localparam string TRACE_PATH = "verification/board_glue_trace.txt";
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int RANDOM_SEED = 15;

    logic                zynq_pl_clk;
    logic                zynq_pl_reset;
    logic                clk_locked;
    board_pkg::gpio_t    gpio_raw;
    board_pkg::irq_vec_t irq;
    board_pkg::gpio_t    gpio_clean;
    board_pkg::irq_vec_t zynq_irq;
    logic                core_reset;
    logic                ddr_reset;

    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          trace_cycles;
    logic        trace_found;
    int          seed_discard;
    logic [31:0] rand_word;

    tb_clock_gen clock_gen_i (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset)
    );

    zynq_board_glue dut_i (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .clk_locked    (clk_locked),
        .gpio_raw      (gpio_raw),
        .irq           (irq),
        .gpio_clean    (gpio_clean),
        .zynq_irq      (zynq_irq),
        .core_reset    (core_reset),
        .ddr_reset     (ddr_reset)
    );

    board_glue_checker checker_i (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .clk_locked    (clk_locked),
        .core_reset    (core_reset),
        .ddr_reset     (ddr_reset),
        .gpio_clean    (gpio_clean),
        .zynq_irq      (zynq_irq)
    );

    function automatic int signal_code(input string sig);
        if (sig == "core") return 0;
        if (sig == "ddr") return 1;
        if (sig == "gpio") return 2;
        if (sig == "irq") return 3;
        return -1;
    endfunction

    // First pass, only waits and pulses take cycles
    task automatic sum_trace_cycles(output int total, output logic opened);
        int    fd;
        int    code;
        int    count;
        string line;
        string cmd;
        total = 0;
        opened = 1'b0;
        fd = $fopen(TRACE_PATH, "r");
        if (fd != 0) begin
            opened = 1'b1;
            while ($fgets(line, fd) > 0) begin
                cmd = "";
                code = $sscanf(line, "%s %d", cmd, count);
                if (cmd == "W" && code == 2) begin
                    total += count;
                end else if (cmd == "I") begin
                    total += 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge zynq_pl_clk);
        #(DRIVE_DELAY);
    endtask

    task automatic pulse_irq(input board_pkg::irq_vec_t mask);
        irq = mask;
        wait_cycles(1);
        irq = '0;
    endtask

    task automatic replay_trace();
        int          fd;
        int          code;
        int          count;
        int          sel;
        string       line;
        string       cmd;
        string       sig;
        string       name;
        logic [31:0] value;
        fd = $fopen(TRACE_PATH, "r");
        while ($fgets(line, fd) > 0) begin
            cmd = "";
            code = $sscanf(line, "%s", cmd);
            if (code < 1 || cmd.substr(0, 0) == "#") begin
                continue;
            end
            if (cmd == "C") begin
                code = $sscanf(line, "%s %s %h %s", cmd, sig, value, name);
                sel = signal_code(sig);
                if (code != 4 || sel < 0) begin
                    checker_i.flag_problem({"Bad expect line in trace for signal ", sig});
                end else begin
                    checker_i.post_expect(name, sel, value);
                end
            end else if (cmd == "W") begin
                code = $sscanf(line, "%s %d", cmd, count);
                wait_cycles(count);
            end else begin
                code = $sscanf(line, "%s %h", cmd, value);
                if (code != 2) begin
                    checker_i.flag_problem({"Trace command without a value: ", cmd});
                end else if (cmd == "L") begin
                    clk_locked = value[0];
                end else if (cmd == "G") begin
                    gpio_raw = value[board_pkg::GPIO_WIDTH-1:0];
                end else if (cmd == "I") begin
                    pulse_irq(value);
                end else begin
                    checker_i.flag_problem({"Unknown trace command: ", cmd});
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        seed_discard = $urandom(RANDOM_SEED);
        rand_word = $urandom;
        gpio_raw = rand_word[board_pkg::GPIO_WIDTH-1:0];
        irq = $urandom;
        clk_locked = 1'b0;
        sum_trace_cycles(trace_cycles, trace_found);
        cycle_limit = trace_cycles + TIMEOUT_MARGIN;
        @(negedge zynq_pl_reset);
        irq = '0;
        if (trace_found) begin
            replay_trace();
        end else begin
            checker_i.flag_problem({"Trace file could not be opened: ", TRACE_PATH});
        end
        repeat (2) @(posedge zynq_pl_clk);
        $display("Trace checks %0d, errors %0d", checker_i.check_count, checker_i.error_count);
        if (checker_i.error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    always @(posedge zynq_pl_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: trace still running after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/board_glue_trace.txt
# Commands: L lock_level | G gpio_hex | I irq_mask_hex | W decimal_cycles
# C signal(core ddr gpio irq) expected_hex test_name
G 0000
C ddr 1 ddr_reset_at_release
C core 1 core_reset_at_release
W 1
C ddr 0 ddr_reset_one_cycle_later
W 20
C core 1 core_reset_without_lock
C irq 00000000 irq_quiet_without_lock
L 1
W 5
C core 1 core_reset_lock_hold
W 3
C core 0 core_reset_lock_release
C gpio 0000 gpio_clean_after_reset
# Stable change on buttons and switches
G 1a5c
W 100
C gpio 1a5c gpio_stable_change
# Every bit glitches for 30 cycles
G 05a3
W 30
C gpio 1a5c gpio_during_glitch
G 1a5c
W 100
C gpio 1a5c gpio_after_glitch
# Single pulse on lines 0, 7 and 16
C irq 00000000 irq_idle
I 00010081
C irq 00010081 irq_pulse_first_cycle
W 9
C irq 00010081 irq_pulse_last_cycle
W 1
C irq 00000000 irq_pulse_done
# Two pulses on line 3, 5 cycles apart
I 00000008
C irq 00000008 irq_merge_first
W 4
C irq 00000008 irq_merge_gap
I 00000008
W 9
C irq 00000008 irq_merge_last
W 1
C irq 00000000 irq_merge_done
# Lock loss with a pulse in flight
I 00000100
C irq 00000100 irq_before_lock_loss
L 0
W 3
C core 1 core_reset_lock_lost
C irq 00000000 irq_cleared_lock_lost
G 0000
W 60
C gpio 1a5c gpio_frozen_in_reset
C core 1 core_reset_lock_still_lost
L 1
W 5
C core 1 core_reset_relock_hold
W 3
C core 0 core_reset_relock_release
W 100
C gpio 0000 gpio_after_relock
W 10

//--- all.f
design/board_pkg.sv
design/board_ctrl.sv
design/gpio_debounce.sv
design/irq_stretch.sv
design/zynq_board_glue.sv
verification/tb_clock_gen.sv
verification/board_glue_checker.sv
verification/board_glue_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module board_glue_tb \
    -f all.f -o board_glue_sim

status=0
./obj_dir/board_glue_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
exit 0
